// ==== board_top.f ====
logic/board_pkg.sv
logic/key_debounce.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/seg_scan.sv
logic/panel_ctrl.sv
logic/board_top.sv
bench/tb_board_top.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_board_top
FILELIST := board_top.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_board_top.sv ====
//****************************************
// testbench for board_top with uart and key
// drivers, uart monitor, panel model, checks
//****************************************
`timescale 1ns/1ps

module tb_board_top;

	localparam int CPB = board_pkg::CLKS_PER_BIT;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic [7:0] led;
	logic       bepeer;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;

	integer seed;
	int     errors;
	int     tests;
	int     tests_failed;

	// reference model of the panel registers
	board_pkg::byte_t m_last;
	board_pkg::byte_t m_count;
	board_pkg::byte_t m_sent;
	board_pkg::keys_t m_flags;
	logic [3:0]       m_presses;

	board_pkg::byte_t rx_byte;
	logic             rx_got;
	logic             flag_seen;
	logic             beep_seen;

	board_top #(
		.debounce_cycles (50),
		.scan_cycles     (20)
	) u_board_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.led          (led),
		.bepeer       (bepeer),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	// 50 MHz
	always #10 sys_clk = ~sys_clk;

	task automatic report_error(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - errs_before);
		end
	endtask

	// active-low segment pattern back to a hex value or 5'h10 for no digit
	function automatic logic [4:0] seg_to_hex(input logic [7:0] seg);
		logic [7:0] lit;
		lit = ~seg;
		case (lit)
			8'h3F: seg_to_hex = 5'h0;
			8'h06: seg_to_hex = 5'h1;
			8'h5B: seg_to_hex = 5'h2;
			8'h4F: seg_to_hex = 5'h3;
			8'h66: seg_to_hex = 5'h4;
			8'h6D: seg_to_hex = 5'h5;
			8'h7D: seg_to_hex = 5'h6;
			8'h07: seg_to_hex = 5'h7;
			8'h7F: seg_to_hex = 5'h8;
			8'h6F: seg_to_hex = 5'h9;
			8'h77: seg_to_hex = 5'hA;
			8'h7C: seg_to_hex = 5'hB;
			8'h39: seg_to_hex = 5'hC;
			8'h5E: seg_to_hex = 5'hD;
			8'h79: seg_to_hex = 5'hE;
			8'h71: seg_to_hex = 5'hF;
			default: seg_to_hex = 5'h10;
		endcase
	endfunction

	// one 8N1 frame into the dut with the lsb first
	task automatic send_frame(input board_pkg::byte_t data);
		@(posedge sys_clk);
		uart_rx_port <= 1'b0;
		repeat (CPB) @(posedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port <= data[i];
			repeat (CPB) @(posedge sys_clk);
		end
		uart_rx_port <= 1'b1;
		repeat (CPB) @(posedge sys_clk);
	endtask

	// capture one frame from uart_tx_port at bit centres
	task automatic receive_frame(input int start_timeout, output board_pkg::byte_t data,
			output logic got);
		logic seen;
		seen = 1'b0;
		data = '0;
		got  = 1'b0;
		for (int t = 0; t < start_timeout && !seen; t++) begin
			@(negedge sys_clk);
			if (uart_tx_port == 1'b0)
				seen = 1'b1;
		end
		if (seen) begin
			repeat (CPB / 2) @(negedge sys_clk);
			if (uart_tx_port !== 1'b0) begin
				errors++;
				$display("start bit on uart_tx_port was not low at its centre, %0t ns", $time);
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge sys_clk);
				data[i] = uart_tx_port;
			end
			repeat (CPB) @(negedge sys_clk);
			if (uart_tx_port !== 1'b1) begin
				errors++;
				$display("stop bit on uart_tx_port was low, %0t ns", $time);
			end
			got = 1'b1;
		end
	endtask

	// bouncy press with short glitches then steady low then release
	task automatic press_key(input int k);
		int n_glitch;
		int len;
		n_glitch = 2 + ({$random(seed)} % 3);
		for (int g = 0; g < n_glitch; g++) begin
			@(posedge sys_clk);
			key_in[k] <= 1'b0;
			len = 1 + ({$random(seed)} % 40);
			repeat (len) @(posedge sys_clk);
			key_in[k] <= 1'b1;
			len = 1 + ({$random(seed)} % 40);
			repeat (len) @(posedge sys_clk);
		end
		key_in[k] <= 1'b0;
		repeat (100) @(posedge sys_clk);
		key_in[k] <= 1'b1;
		// let the release be accepted before the next key
		repeat (120) @(posedge sys_clk);
	endtask

	// wait for the flags to move and then look for a buzzer edge
	task automatic watch_press(input board_pkg::keys_t old_flags, output logic flags_moved,
			output logic beeped);
		logic prev_bp;
		int   t;
		flags_moved = 1'b0;
		beeped      = 1'b0;
		@(negedge sys_clk);
		prev_bp = bepeer;
		for (t = 0; t < 1000 && !flags_moved; t++) begin
			@(negedge sys_clk);
			if (led[3:0] != old_flags)
				flags_moved = 1'b1;
			else
				prev_bp = bepeer;
		end
		t = 0;
		while (flags_moved && !beeped && t < 1000) begin
			if (bepeer != prev_bp)
				beeped = 1'b1;
			prev_bp = bepeer;
			@(negedge sys_clk);
			t++;
		end
	endtask

	// one full scan against the model digits and then led
	task automatic check_display();
		board_pkg::disp_t exp;
		logic [7:0]       want;
		logic [4:0]       hex;
		logic             found;
		exp = {m_last, m_count, m_sent, m_flags, m_presses};
		for (int d = 0; d < 8; d++) begin
			want  = ~(8'h01 << d);
			found = 1'b0;
			for (int t = 0; t < 400 && !found; t++) begin
				@(negedge sys_clk);
				if (seg_choice == want)
					found = 1'b1;
			end
			if (!found) begin
				errors++;
				$display("timeout: seg_choice never enabled digit %0d", d);
			end else begin
				hex = seg_to_hex(seg_number);
				if (hex !== {1'b0, exp[d*4 +: 4]})
					report_error($sformatf("seg_number digit %0d", d), 32'(hex),
						32'(exp[d*4 +: 4]));
			end
		end
		if (led !== {m_last[7:4], m_flags})
			report_error("led", 32'(led), 32'({m_last[7:4], m_flags}));
	endtask

	initial begin
		int               mark;
		logic             bad;
		int               k;
		board_pkg::byte_t b;
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		key_in       = 4'hF;
		uart_rx_port = 1'b1;
		seed         = 32'h3b80;
		errors       = 0;
		tests        = 0;
		tests_failed = 0;
		m_last       = '0;
		m_count      = '0;
		m_sent       = '0;
		m_flags      = '0;
		m_presses    = '0;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		// idle outputs after reset
		mark = errors;
		bad  = 1'b0;
		for (int i = 0; i < 100 && !bad; i++) begin
			@(negedge sys_clk);
			if (uart_tx_port !== 1'b1) begin
				bad = 1'b1;
				report_error("uart_tx_port", 32'(uart_tx_port), 32'd1);
			end
			if (bepeer !== 1'b0) begin
				bad = 1'b1;
				report_error("bepeer", 32'(bepeer), 32'd0);
			end
			if (led !== 8'h00) begin
				bad = 1'b1;
				report_error("led", 32'(led), 32'd0);
			end
		end
		end_test("reset", mark);

		// echo of random bytes
		mark = errors;
		for (int n = 0; n < 12; n++) begin
			b = 8'($random(seed));
			fork
				send_frame(b);
				receive_frame(15 * CPB, rx_byte, rx_got);
			join
			if (!rx_got) begin
				errors++;
				$display("timeout: no echo frame for byte 0x%0h", b);
			end else if (rx_byte !== b) begin
				report_error("uart_tx_port echo", 32'(rx_byte), 32'(b));
			end
			m_last  = b;
			m_count = m_count + 8'd1;
		end
		end_test("echo", mark);

		mark = errors;
		check_display();
		end_test("display", mark);

		// keys 0 to 2 toggle their flag and beep
		mark = errors;
		for (int n = 0; n < 6; n++) begin
			k = {$random(seed)} % 3;
			fork
				press_key(k);
				watch_press(m_flags, flag_seen, beep_seen);
			join
			m_flags[k] = ~m_flags[k];
			m_presses  = m_presses + 4'd1;
			if (!flag_seen) begin
				errors++;
				$display("timeout: press of key %0d never changed the led flags", k);
			end else if (!beep_seen) begin
				errors++;
				$display("bepeer did not toggle within 1000 cycles of key %0d press", k);
			end
			if (led !== {m_last[7:4], m_flags})
				report_error("led", 32'(led), 32'({m_last[7:4], m_flags}));
		end
		end_test("keys", mark);

		// key 3 sends the count and clears it
		mark = errors;
		fork
			press_key(3);
			receive_frame(2000, rx_byte, rx_got);
		join
		if (!rx_got) begin
			errors++;
			$display("timeout: key 3 press sent no count frame");
		end else if (rx_byte !== m_count) begin
			report_error("uart_tx_port count", 32'(rx_byte), 32'(m_count));
		end
		m_sent     = m_count;
		m_count    = '0;
		m_flags[3] = ~m_flags[3];
		m_presses  = m_presses + 4'd1;
		check_display();
		end_test("count send", mark);

		$display("tests run %0d, tests failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/board_top.sv ====
//****************************************
// front panel top level, keys, uart echo,
// display scanner and buzzer
//****************************************
`timescale 1ns/1ps

module board_top #(
	parameter int debounce_cycles = board_pkg::DEBOUNCE_CYCLES,
	parameter int scan_cycles     = board_pkg::SCAN_CYCLES
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	input  logic       uart_rx_port,
	output logic       uart_tx_port,
	output logic [7:0] led,
	output logic       bepeer,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	board_pkg::keys_t press;
	board_pkg::byte_t rx_data;
	logic             rx_valid;
	board_pkg::byte_t tx_data;
	logic             tx_start;
	logic             tx_busy;
	board_pkg::disp_t disp;

	// push keys
	key_debounce #(
		.debounce_cycles (debounce_cycles)
	) u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.press     (press)
	);

	// serial in and out
	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid)
	);

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_data      (tx_data),
		.tx_start     (tx_start),
		.uart_tx_port (uart_tx_port),
		.tx_busy      (tx_busy)
	);

	// registers steering display, transmitter and buzzer
	panel_ctrl u_panel_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.press     (press),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.tx_busy   (tx_busy),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.disp      (disp),
		.led       (led),
		.bepeer    (bepeer)
	);

	seg_scan #(
		.scan_cycles (scan_cycles)
	) u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.disp       (disp),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

// ==== logic/panel_ctrl.sv ====
//****************************************
// panel registers, echo and count transmit
// arbitration, beep timer
//****************************************
`timescale 1ns/1ps

module panel_ctrl (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  board_pkg::keys_t  press,
	input  board_pkg::byte_t  rx_data,
	input  logic              rx_valid,
	input  logic              tx_busy,
	output board_pkg::byte_t  tx_data,
	output logic              tx_start,
	output board_pkg::disp_t  disp,
	output logic [7:0]        led,
	output logic              bepeer
);

	localparam int BEEP_W = $clog2(board_pkg::BEEP_CYCLES);
	localparam int TONE_W = $clog2(board_pkg::TONE_HALF);

	board_pkg::byte_t last_byte;
	board_pkg::byte_t rx_count;
	board_pkg::byte_t sent_count;
	board_pkg::keys_t flags;
	logic [3:0]       press_cnt;
	logic             echo_pend;
	logic             cnt_pend;
	logic [BEEP_W-1:0] beep_cnt;
	logic [TONE_W-1:0] tone_cnt;

	logic             echo_req;
	logic             cnt_req;
	logic             tx_free;
	logic             send_echo;
	logic             send_cnt;
	board_pkg::byte_t echo_byte;
	board_pkg::byte_t cnt_byte;

	// new requests this cycle or latched ones
	assign echo_req = rx_valid | echo_pend;
	assign cnt_req  = press[3] | cnt_pend;
	// a byte arriving now replaces a pending echo
	assign echo_byte = rx_valid ? rx_data : last_byte;
	assign cnt_byte  = press[3] ? rx_count : sent_count;

	// transmitter sees the strobe one cycle before busy rises
	assign tx_free   = !tx_busy && !tx_start;
	assign send_echo = tx_free && echo_req;
	assign send_cnt  = tx_free && !echo_req && cnt_req;

	assign disp = {last_byte, rx_count, sent_count, flags, press_cnt};
	assign led  = {last_byte[7:4], flags};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			last_byte  <= '0;
			rx_count   <= '0;
			sent_count <= '0;
			flags      <= '0;
			press_cnt  <= '0;
			echo_pend  <= 1'b0;
			cnt_pend   <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			if (rx_valid)
				last_byte <= rx_data;
			// key 3 moves the count over and restarts it
			if (press[3]) begin
				sent_count <= rx_count;
				rx_count   <= board_pkg::byte_t'(rx_valid);
			end else if (rx_valid) begin
				rx_count <= rx_count + 8'd1;
			end
			flags     <= flags ^ press;
			press_cnt <= press_cnt + 4'($countones(press));
			echo_pend <= echo_req && !send_echo;
			cnt_pend  <= cnt_req && !send_cnt;
			tx_start  <= send_echo || send_cnt;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (send_echo)
			tx_data <= echo_byte;
		else if (send_cnt)
			tx_data <= cnt_byte;
	end

	// beep timer and tone divider
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_cnt <= '0;
			tone_cnt <= '0;
			bepeer   <= 1'b0;
		end else if (|press) begin
			// restart, first edge right away
			beep_cnt <= BEEP_W'(board_pkg::BEEP_CYCLES - 1);
			tone_cnt <= '0;
			bepeer   <= ~bepeer;
		end else if (beep_cnt != '0) begin
			beep_cnt <= beep_cnt - 1'b1;
			if (tone_cnt == TONE_W'(board_pkg::TONE_HALF - 1)) begin
				tone_cnt <= '0;
				bepeer   <= ~bepeer;
			end else begin
				tone_cnt <= tone_cnt + 1'b1;
			end
		end else begin
			bepeer <= 1'b0;
		end
	end

endmodule

// ==== logic/seg_scan.sv ====
//****************************************
// eight-digit display scanner and hex to
// active-low segment decoder
//****************************************
`timescale 1ns/1ps

module seg_scan #(
	parameter int scan_cycles = board_pkg::SCAN_CYCLES
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  board_pkg::disp_t  disp,
	output logic [7:0]        seg_number,
	output logic [7:0]        seg_choice
);

	localparam int CNT_W = $clog2(scan_cycles);

	logic [CNT_W-1:0] scan_cnt;
	logic [2:0]       digit;
	logic [2:0]       digit_next;
	logic [3:0]       nibble;

	// hex value to segments g..a, low means lit
	function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
		case (hex)
			4'h0: hex_to_seg = 7'h40;
			4'h1: hex_to_seg = 7'h79;
			4'h2: hex_to_seg = 7'h24;
			4'h3: hex_to_seg = 7'h30;
			4'h4: hex_to_seg = 7'h19;
			4'h5: hex_to_seg = 7'h12;
			4'h6: hex_to_seg = 7'h02;
			4'h7: hex_to_seg = 7'h78;
			4'h8: hex_to_seg = 7'h00;
			4'h9: hex_to_seg = 7'h10;
			4'hA: hex_to_seg = 7'h08;
			4'hB: hex_to_seg = 7'h03;
			4'hC: hex_to_seg = 7'h46;
			4'hD: hex_to_seg = 7'h21;
			4'hE: hex_to_seg = 7'h06;
			default: hex_to_seg = 7'h0E;
		endcase
	endfunction

	assign digit_next = digit + 1'b1;

	// nibble of the digit about to light
	assign nibble = disp[{digit_next, 2'b00} +: 4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			digit      <= '0;
			seg_choice <= 8'hFE;
			// digit 0 showing 0, point off
			seg_number <= 8'hC0;
		end else if (scan_cnt == CNT_W'(scan_cycles - 1)) begin
			scan_cnt   <= '0;
			digit      <= digit_next;
			// enable and pattern change in the same edge
			seg_choice <= ~(8'h01 << digit_next);
			seg_number <= {1'b1, hex_to_seg(nibble)};
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

endmodule

// ==== logic/uart_tx.sv ====
//****************************************
// 8N1 uart transmitter with start strobe
// and busy level
//****************************************
`timescale 1ns/1ps

module uart_tx (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  board_pkg::byte_t  tx_data,
	input  logic              tx_start,
	output logic              uart_tx_port,
	output logic              tx_busy
);

	localparam int CPB   = board_pkg::CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	board_pkg::tx_state_t state;
	logic [CNT_W-1:0]     clk_cnt;
	logic [2:0]           bit_idx;
	board_pkg::byte_t     shift;
	logic                 bit_tick;

	assign bit_tick = (clk_cnt == CNT_W'(CPB - 1));

	// busy from the cycle after the strobe until the stop bit ends
	assign tx_busy = (state != board_pkg::TX_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= board_pkg::TX_IDLE;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
			case (state)
				board_pkg::TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (tx_start) begin
						uart_tx_port <= 1'b0;
						state        <= board_pkg::TX_START;
					end
				end
				board_pkg::TX_START: begin
					if (bit_tick) begin
						uart_tx_port <= shift[0];
						state        <= board_pkg::TX_DATA;
					end
				end
				board_pkg::TX_DATA: begin
					if (bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						// after bit 7 the line goes to the stop level
						if (bit_idx == 3'd7) begin
							uart_tx_port <= 1'b1;
							state        <= board_pkg::TX_STOP;
						end else begin
							uart_tx_port <= shift[1];
						end
					end
				end
				default: begin
					if (bit_tick)
						state <= board_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// byte latch and shifter
	always_ff @(posedge sys_clk) begin
		if (state == board_pkg::TX_IDLE && tx_start)
			shift <= tx_data;
		else if (state == board_pkg::TX_DATA && bit_tick)
			shift <= shift >> 1;
	end

endmodule

// ==== logic/uart_rx.sv ====
//****************************************
// 8N1 uart receiver, mid-bit sampling,
// byte strobe on a good stop bit
//****************************************
`timescale 1ns/1ps

module uart_rx (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              uart_rx_port,
	output board_pkg::byte_t  rx_data,
	output logic              rx_valid
);

	localparam int CPB   = board_pkg::CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	logic                 rx_sync1;
	logic                 rx_sync2;
	logic                 rx_prev;
	board_pkg::rx_state_t state;
	logic [CNT_W-1:0]     clk_cnt;
	logic [2:0]           bit_idx;
	board_pkg::byte_t     shift;
	logic                 bit_tick;
	logic                 half_tick;

	// end of a full bit and of half a bit
	assign bit_tick  = (clk_cnt == CNT_W'(CPB - 1));
	assign half_tick = (clk_cnt == CNT_W'(CPB / 2 - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync1 <= 1'b1;
			rx_sync2 <= 1'b1;
			rx_prev  <= 1'b1;
			state    <= board_pkg::RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync1 <= uart_rx_port;
			rx_sync2 <= rx_sync1;
			rx_prev  <= rx_sync2;
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				board_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					// falling start edge
					if (rx_prev && !rx_sync2)
						state <= board_pkg::RX_START;
				end
				board_pkg::RX_START: begin
					// start bit must still be low at its centre
					if (half_tick) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync2 ? board_pkg::RX_IDLE : board_pkg::RX_DATA;
					end
				end
				board_pkg::RX_DATA: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= board_pkg::RX_STOP;
					end
				end
				default: begin
					// low stop bit drops the frame
					if (bit_tick) begin
						rx_valid <= rx_sync2;
						state    <= board_pkg::RX_IDLE;
					end
				end
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == board_pkg::RX_DATA && bit_tick)
			shift <= {rx_sync2, shift[7:1]};
		if (state == board_pkg::RX_STOP && bit_tick && rx_sync2)
			rx_data <= shift;
	end

endmodule

// ==== logic/key_debounce.sv ====
//****************************************
// four-key synchronizer and debouncer with
// one-cycle press strobes
//****************************************
`timescale 1ns/1ps

module key_debounce #(
	parameter int debounce_cycles = board_pkg::DEBOUNCE_CYCLES
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  board_pkg::keys_t  key_in,
	output board_pkg::keys_t  press
);

	localparam int NUM_KEYS = $bits(board_pkg::keys_t);
	localparam int CNT_W    = $clog2(debounce_cycles + 1);

	// two-flop synchronizer, keys idle high
	board_pkg::keys_t key_sync1;
	board_pkg::keys_t key_sync2;

	// accepted stable level per key
	board_pkg::keys_t level;

	// per-key stability counters
	logic [CNT_W-1:0] cnt [NUM_KEYS];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_sync1 <= '1;
			key_sync2 <= '1;
		end else begin
			key_sync1 <= key_in;
			key_sync2 <= key_sync1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level <= '1;
			press <= '0;
			cnt   <= '{default: '0};
		end else begin
			for (int i = 0; i < NUM_KEYS; i++) begin
				press[i] <= 1'b0;
				// back at the accepted level, bounce or no change
				if (key_sync2[i] == level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == CNT_W'(debounce_cycles)) begin
					cnt[i]   <= '0;
					level[i] <= key_sync2[i];
					// only a fall to low counts as a press
					press[i] <= ~key_sync2[i];
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/board_pkg.sv ====
//****************************************
// shared clock, uart, debounce, scan and beep
// constants, vector types and uart fsm states
//****************************************
package board_pkg;

	// board clock and serial line rate
	localparam int CLK_FREQ = 50_000_000;
	localparam int BAUD     = 115_200;

	// sys_clk cycles per uart bit, 434
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;

	// 20 ms key stability window
	localparam int DEBOUNCE_CYCLES = 1_000_000;

	// 1 ms per lit digit
	localparam int SCAN_CYCLES = 50_000;

	// 100 ms beep
	localparam int BEEP_CYCLES = 5_000_000;

	// half period of a 2 kHz tone
	localparam int TONE_HALF = 12_500;

	// uart data and byte counts
	typedef logic [7:0] byte_t;

	// one bit per push key
	typedef logic [3:0] keys_t;

	// eight hex digits, digit 7 in the top nibble
	typedef logic [31:0] disp_t;

	// receiver and transmitter states
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage
